// ==== include/wb_defines.svh ====
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// ########################################
// Write-back path dimensions
// ########################################

// Number of line buffers that can hold evicted lines at once.
`define WB_NUM_BUFFERS 4

// Width of a buffer index, sized for WB_NUM_BUFFERS.
`define WB_IDX_W 2

// A cache line is sixteen 32-bit words.
`define WB_LINE_WORDS 16
`define WB_LINE_W 512

// AXI write bus widths.
`define WB_ADDR_W 32
`define WB_DATA_W 32

// AXI burst length field.
`define WB_LEN_W 8

// Response code width on the B channel.
`define WB_RESP_W 2

`endif

// ==== source/wb_pkg.sv ====
`include "wb_defines.svh"

package wb_pkg;

    // ########################################
    // Payload structs
    // ########################################

    // Eviction request as it arrives from the cache.
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_LINE_W-1:0] line;
        logic                  uncache;
    } wb_req_t;

    // Address-channel fields; len is beats minus one.
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_LEN_W-1:0]  len;
    } wb_aw_t;

    // One W-channel beat.
    typedef struct packed {
        logic [`WB_DATA_W-1:0] data;
        logic                  last;
    } wb_beat_t;

    // ########################################
    // State encodings
    // ########################################

    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_PENDING,
        BUF_SEND,
        BUF_RESP
    } buf_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA
    } arb_state_e;

endpackage

// ==== source/wb_dispatch.sv ====
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_dispatch import wb_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       in_valid,
    input  wb_req_t                    in_req,
    input  logic [`WB_NUM_BUFFERS-1:0] free,
    output logic                       in_ready,
    output logic [`WB_NUM_BUFFERS-1:0] load,
    output wb_req_t                    load_req
);

    logic [`WB_NUM_BUFFERS-1:0] avail;
    logic [`WB_NUM_BUFFERS-1:0] sel;
    logic                       found;
    logic                       xfer;

    // A buffer whose load strobe is in flight still reports free for one
    // more cycle, so it is masked out here.
    assign avail    = free & ~load;
    assign in_ready = |avail;
    assign xfer     = in_valid && in_ready;

    // ########################################
    // Lowest free buffer
    // ########################################

    always_comb begin
        sel   = '0;
        found = 1'b0;
        for (int i = 0; i < `WB_NUM_BUFFERS; i++) begin
            if (avail[i] && !found) begin
                sel[i] = 1'b1;
                found  = 1'b1;
            end
        end
    end

    // ########################################
    // Registered load strobe and request
    // ########################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            load <= '0;
        end else if (xfer) begin
            load <= sel;
        end else begin
            load <= '0;
        end
    end

    // The wide request is captured once here and then broadcast.
    always_ff @(posedge clk) begin
        if (xfer) begin
            load_req <= in_req;
        end
    end

endmodule

// ==== source/wb_line_buffer.sv ====
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_line_buffer import wb_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     load,
    input  wb_req_t  load_req,
    input  logic     aw_done,
    input  logic     beat_ready,
    input  logic     resp_valid,
    output logic     free,
    output logic     pending,
    output wb_aw_t   aw,
    output wb_beat_t beat,
    output logic     beat_valid,
    output logic     resp_ready,
    output logic     done
);

    localparam int CNT_W = $clog2(`WB_LINE_WORDS);

    buf_state_e            state;
    logic [CNT_W-1:0]      count;
    logic [`WB_ADDR_W-1:0] addr_q;
    logic [`WB_LINE_W-1:0] line_q;
    logic                  uncache_q;
    logic                  beat_fire;

    // ########################################
    // Stored line
    // ########################################

    always_ff @(posedge clk) begin
        if (load && state == BUF_IDLE) begin
            addr_q    <= load_req.addr;
            line_q    <= load_req.line;
            uncache_q <= load_req.uncache;
        end
    end

    // An uncached store goes out as a single beat.
    assign aw.addr = addr_q;
    assign aw.len  = uncache_q ? '0 : `WB_LEN_W'(`WB_LINE_WORDS - 1);

    // ########################################
    // Buffer FSM
    // ########################################

    assign beat_fire = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= BUF_IDLE;
            count <= '0;
        end else begin
            case (state)
                BUF_IDLE: begin
                    if (load) begin
                        state <= BUF_PENDING;
                    end
                end
                BUF_PENDING: begin
                    count <= '0;
                    if (aw_done) begin
                        state <= BUF_SEND;
                    end
                end
                BUF_SEND: begin
                    if (beat_fire) begin
                        count <= count + 1'b1;
                        if (beat.last) begin
                            state <= BUF_RESP;
                        end
                    end
                end
                BUF_RESP: begin
                    if (resp_valid) begin
                        state <= BUF_IDLE;
                    end
                end
                default: begin
                    state <= BUF_IDLE;
                end
            endcase
        end
    end

    assign free       = (state == BUF_IDLE);
    assign pending    = (state == BUF_PENDING);
    assign beat_valid = (state == BUF_SEND);
    assign resp_ready = (state == BUF_RESP);
    assign done       = resp_ready && resp_valid;

    // ########################################
    // Beat selection
    // ########################################

    // The counter picks the word; it stays at zero for an uncached store.
    assign beat.data = line_q[count*`WB_DATA_W +: `WB_DATA_W];
    assign beat.last = uncache_q || (count == CNT_W'(`WB_LINE_WORDS - 1));

endmodule

// ==== source/wb_write_arbiter.sv ====
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_write_arbiter import wb_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`WB_NUM_BUFFERS-1:0] pending,
    input  wb_aw_t                     buf_aw     [`WB_NUM_BUFFERS],
    input  wb_beat_t                   beat       [`WB_NUM_BUFFERS],
    input  logic [`WB_NUM_BUFFERS-1:0] beat_valid,
    input  logic [`WB_NUM_BUFFERS-1:0] resp_ready,
    input  logic [`WB_NUM_BUFFERS-1:0] done,
    input  logic                       aw_ready,
    input  logic                       w_ready,
    input  logic                       b_valid,
    output logic [`WB_NUM_BUFFERS-1:0] aw_done,
    output logic [`WB_NUM_BUFFERS-1:0] beat_ready,
    output logic [`WB_NUM_BUFFERS-1:0] resp_valid,
    output logic                       aw_valid,
    output wb_aw_t                     aw,
    output logic                       w_valid,
    output wb_beat_t                   w,
    output logic                       b_ready
);

    arb_state_e            state;
    logic [`WB_IDX_W-1:0] grant;
    logic [`WB_IDX_W-1:0] last_grant;
    logic [`WB_IDX_W-1:0] next_grant;
    logic [`WB_IDX_W-1:0] cand;
    logic                  found;
    logic                  in_data;

    // ########################################
    // Round-robin search
    // ########################################

    // The search starts one past the buffer granted last time.
    always_comb begin
        next_grant = last_grant;
        found      = 1'b0;
        cand       = last_grant;
        for (int k = 1; k <= `WB_NUM_BUFFERS; k++) begin
            cand = last_grant + `WB_IDX_W'(k);
            if (pending[cand] && !found) begin
                next_grant = cand;
                found      = 1'b1;
            end
        end
    end

    // ########################################
    // Arbiter FSM
    // ########################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            last_grant <= `WB_IDX_W'(`WB_NUM_BUFFERS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant      <= next_grant;
                        last_grant <= next_grant;
                        state      <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (aw_ready) begin
                        state <= ARB_DATA;
                    end
                end
                ARB_DATA: begin
                    // The buffer alone knows when its burst and response are over.
                    if (done[grant]) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // ########################################
    // Channel steering
    // ########################################

    assign in_data = (state == ARB_DATA);

    assign aw_valid = (state == ARB_ADDR);
    assign aw       = buf_aw[grant];

    assign w_valid = in_data && beat_valid[grant];
    assign w       = beat[grant];
    assign b_ready = in_data && resp_ready[grant];

    always_comb begin
        for (int i = 0; i < `WB_NUM_BUFFERS; i++) begin
            aw_done[i]    = aw_valid && aw_ready && (grant == i);
            beat_ready[i] = in_data && w_ready && (grant == i);
            resp_valid[i] = in_data && b_valid && (grant == i);
        end
    end

endmodule

// ==== source/wb_top.sv ====
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_top import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    input  wb_req_t               in_req,
    input  logic                  aw_ready,
    input  logic                  w_ready,
    input  logic                  b_valid,
    input  logic [`WB_RESP_W-1:0] b_resp,
    output logic                  in_ready,
    output logic                  aw_valid,
    output wb_aw_t                aw,
    output logic                  w_valid,
    output wb_beat_t              w,
    output logic                  b_ready
);

    logic [`WB_NUM_BUFFERS-1:0] free;
    logic [`WB_NUM_BUFFERS-1:0] load;
    wb_req_t                    load_req;
    logic [`WB_NUM_BUFFERS-1:0] pending;
    wb_aw_t                     buf_aw [`WB_NUM_BUFFERS];
    logic [`WB_NUM_BUFFERS-1:0] aw_done;
    wb_beat_t                   beat [`WB_NUM_BUFFERS];
    logic [`WB_NUM_BUFFERS-1:0] beat_valid;
    logic [`WB_NUM_BUFFERS-1:0] beat_ready;
    logic [`WB_NUM_BUFFERS-1:0] resp_valid;
    logic [`WB_NUM_BUFFERS-1:0] resp_ready;
    logic [`WB_NUM_BUFFERS-1:0] done;

    wb_dispatch dispatch_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_req   (in_req),
        .free     (free),
        .in_ready (in_ready),
        .load     (load),
        .load_req (load_req)
    );

    // b_resp is left to the bus side; the design only completes on the handshake.
    for (genvar i = 0; i < `WB_NUM_BUFFERS; i++) begin : g_buf
        wb_line_buffer buf_i (
            .clk        (clk),
            .rstn       (rstn),
            .load       (load[i]),
            .load_req   (load_req),
            .aw_done    (aw_done[i]),
            .beat_ready (beat_ready[i]),
            .resp_valid (resp_valid[i]),
            .free       (free[i]),
            .pending    (pending[i]),
            .aw         (buf_aw[i]),
            .beat       (beat[i]),
            .beat_valid (beat_valid[i]),
            .resp_ready (resp_ready[i]),
            .done       (done[i])
        );
    end

    wb_write_arbiter arbiter_i (
        .clk        (clk),
        .rstn       (rstn),
        .pending    (pending),
        .buf_aw     (buf_aw),
        .beat       (beat),
        .beat_valid (beat_valid),
        .resp_ready (resp_ready),
        .done       (done),
        .aw_ready   (aw_ready),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .aw_done    (aw_done),
        .beat_ready (beat_ready),
        .resp_valid (resp_valid),
        .aw_valid   (aw_valid),
        .aw         (aw),
        .w_valid    (w_valid),
        .w          (w),
        .b_ready    (b_ready)
    );

endmodule

// ==== test/wb_axi_slave.sv ====
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_axi_slave import wb_pkg::*; #(
    parameter int SEED = 34532
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      stall_en,
    input  logic                      aw_hold,
    input  logic                      aw_valid,
    input  wb_aw_t                    aw,
    input  logic                      w_valid,
    input  wb_beat_t                  w,
    input  logic                      b_ready,
    output logic                      aw_ready,
    output logic                      w_ready,
    output logic                      b_valid,
    output logic [`WB_RESP_W-1:0]     b_resp,
    output logic                      burst_valid,
    output wb_aw_t                    burst_aw,
    output logic [4:0]                burst_beats,
    output logic [`WB_LINE_W-1:0]     burst_data,
    output logic [`WB_LINE_WORDS-1:0] burst_last
);

    integer                    seed = SEED;
    logic                      run_q = 1'b0;
    logic                      stall_q = 1'b0;
    logic                      hold_q = 1'b0;
    logic                      aw_rdy_q = 1'b0;
    logic                      w_rdy_q = 1'b0;
    logic                      b_vld_q = 1'b0;
    logic                      resp_due;
    logic [4:0]                cnt;
    wb_aw_t                    cur_aw;
    logic [`WB_LINE_W-1:0]     data;
    logic [`WB_LINE_WORDS-1:0] lasts;

    assign aw_ready = aw_rdy_q;
    assign w_ready  = w_rdy_q;
    assign b_valid  = b_vld_q;
    assign b_resp   = '0;

    // ########################################
    // Burst collection on the rising edge
    // ########################################

    always @(posedge clk) begin
        run_q       <= rstn;
        stall_q     <= stall_en;
        hold_q      <= aw_hold;
        burst_valid <= 1'b0;
        if (!rstn) begin
            resp_due <= 1'b0;
            cnt      <= '0;
        end else begin
            if (aw_valid && aw_rdy_q) begin
                cur_aw <= aw;
                cnt    <= '0;
                lasts  <= '0;
            end
            if (w_valid && w_rdy_q) begin
                if (cnt < 5'd16) begin
                    data[cnt[3:0]*`WB_DATA_W +: `WB_DATA_W] <= w.data;
                    lasts[cnt[3:0]] <= w.last;
                end
                cnt <= cnt + 5'd1;
                if (w.last) begin
                    resp_due <= 1'b1;
                end
            end
            // A finished burst is handed over together with its response.
            if (b_vld_q && b_ready) begin
                resp_due    <= 1'b0;
                burst_valid <= 1'b1;
                burst_aw    <= cur_aw;
                burst_beats <= cnt;
                burst_data  <= data;
                burst_last  <= lasts;
            end
        end
    end

    // Ready and valid change on the falling edge. Once raised, b_valid stays up
    // until its handshake.
    always @(negedge clk) begin
        if (!run_q) begin
            aw_rdy_q <= 1'b0;
            w_rdy_q  <= 1'b0;
            b_vld_q  <= 1'b0;
        end else begin
            aw_rdy_q <= !hold_q && (!stall_q || (($random(seed) & 3) != 0));
            w_rdy_q  <= !stall_q || (($random(seed) & 3) != 0);
            if (b_vld_q) begin
                b_vld_q <= resp_due;
            end else begin
                b_vld_q <= resp_due && (!stall_q || (($random(seed) & 1) != 0));
            end
        end
    end

endmodule

// ==== test/wb_tb.sv ====
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_tb import wb_pkg::*; ();

    // Two single requests, five in the back-pressure test and the random mix.
    localparam int TOTAL_REQS = 207;
    localparam int MAX_CYCLES = 200 * TOTAL_REQS;
    localparam logic [`WB_ADDR_W-1:0] ADDR_BASE = 32'h8000_0000;

    logic                      clk;
    logic                      rstn;
    logic                      in_valid;
    wb_req_t                   in_req;
    logic                      in_ready;
    logic                      aw_valid;
    logic                      aw_ready;
    wb_aw_t                    aw;
    logic                      w_valid;
    logic                      w_ready;
    wb_beat_t                  w;
    logic                      b_valid;
    logic                      b_ready;
    logic [`WB_RESP_W-1:0]     b_resp;
    logic                      stall_en;
    logic                      aw_hold;
    logic                      burst_valid;
    wb_aw_t                    burst_aw;
    logic [4:0]                burst_beats;
    logic [`WB_LINE_W-1:0]     burst_data;
    logic [`WB_LINE_WORDS-1:0] burst_last;

    // Scoreboard of outstanding requests, keyed by address.
    logic [`WB_LINE_W-1:0] exp_line [logic [`WB_ADDR_W-1:0]];
    logic                  exp_unc [logic [`WB_ADDR_W-1:0]];

    integer seed = 34532;
    int     next_idx = 0;
    int     sent = 0;
    int     checked = 0;
    int     err_main = 0;
    int     err_chk = 0;
    int     tests_run = 0;
    int     cycles = 0;
    string  test_name = "none";

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    wb_top dut_i (.*);
    wb_axi_slave slave_i (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the bus stopped making progress", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ########################################
    // Helpers
    // ########################################

    task automatic check(inout int err_cnt, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
            err_cnt++;
        end
    endtask

    // Cached lines sit on line boundaries, uncached stores on a word inside their own line.
    task automatic make_req(input logic unc, output wb_req_t req);
        req.uncache = unc;
        req.addr    = ADDR_BASE + (32'(next_idx) << 6);
        if (unc) begin
            req.addr[5:2] = 4'($random(seed));
        end
        for (int i = 0; i < `WB_LINE_WORDS; i++) begin
            req.line[i*`WB_DATA_W +: `WB_DATA_W] = $random(seed);
        end
        next_idx++;
    endtask

    task automatic send_req(input wb_req_t req);
        in_req   = req;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);
        exp_line[req.addr] = req.line;
        exp_unc[req.addr]  = req.uncache;
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (checked < sent) @(negedge clk);
    endtask

    task automatic report_test(input int err_start);
        int n;
        n = err_main + err_chk - err_start;
        tests_run++;
        if (n == 0) begin
            $display("Test %s: ok", test_name);
        end else begin
            $display("Test %s: %0d mismatches", test_name, n);
        end
    endtask

    // ########################################
    // Burst checker
    // ########################################

    // Every burst counts, so one at a wrong address leaves its request in the scoreboard.
    always @(posedge clk) begin : burst_check
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_LINE_W-1:0] line;
        int                    nbeats;
        if (burst_valid === 1'b1) begin
            addr = burst_aw.addr;
            if (!exp_unc.exists(addr)) begin
                $display("Unexpected burst in %s at address %h, no request is outstanding there",
                         test_name, addr);
                err_chk++;
            end else begin
                line   = exp_line[addr];
                nbeats = exp_unc[addr] ? 1 : `WB_LINE_WORDS;
                check(err_chk, "len", 32'(nbeats - 1), 32'(burst_aw.len));
                check(err_chk, "beat count", 32'(nbeats), 32'(burst_beats));
                for (int i = 0; i < nbeats; i++) begin
                    check(err_chk, "beat data", line[i*`WB_DATA_W +: `WB_DATA_W],
                          burst_data[i*`WB_DATA_W +: `WB_DATA_W]);
                    check(err_chk, "last flag", 32'(i == nbeats - 1), 32'(burst_last[i]));
                end
                exp_line.delete(addr);
                exp_unc.delete(addr);
            end
            checked++;
        end
    end

    // ########################################
    // Test sequence
    // ########################################

    initial begin
        wb_req_t req;
        int      start;
        int      ready_seen;
        int      gap;
        int      total;
        logic    unc;

        rstn     = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        stall_en = 1'b0;
        aw_hold  = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        test_name = "reset_state";
        start     = err_main + err_chk;
        repeat (4) begin
            check(err_main, "in_ready", 32'd1, 32'(in_ready));
            check(err_main, "aw_valid", 32'd0, 32'(aw_valid));
            check(err_main, "w_valid", 32'd0, 32'(w_valid));
            check(err_main, "b_ready", 32'd0, 32'(b_ready));
            @(negedge clk);
        end
        report_test(start);

        for (int k = 0; k < 2; k++) begin
            test_name = (k == 0) ? "cached_line" : "uncached_store";
            start     = err_main + err_chk;
            make_req(k[0], req);
            send_req(req);
            wait_drain();
            report_test(start);
        end

        // With the address channel held, every buffer stays occupied.
        test_name = "back_pressure";
        start     = err_main + err_chk;
        aw_hold   = 1'b1;
        repeat (2) @(negedge clk);
        for (int k = 0; k < `WB_NUM_BUFFERS; k++) begin
            make_req(1'b0, req);
            send_req(req);
        end
        make_req(1'b0, req);
        in_req     = req;
        in_valid   = 1'b1;
        ready_seen = 0;
        repeat (20) begin
            if (in_ready) begin
                ready_seen++;
            end
            @(negedge clk);
        end
        check(err_main, "in_ready while full", 32'd0, 32'(ready_seen));
        check(err_main, "bursts while stalled", 32'(sent - `WB_NUM_BUFFERS), 32'(checked));
        aw_hold = 1'b0;
        send_req(req);
        wait_drain();
        report_test(start);

        test_name = "random_mix";
        start     = err_main + err_chk;
        stall_en  = 1'b1;
        for (int k = 0; k < 200; k++) begin
            gap = $random(seed) & 3;
            unc = ($random(seed) & 1) != 0;
            repeat (gap) @(negedge clk);
            make_req(unc, req);
            send_req(req);
        end
        wait_drain();
        stall_en = 1'b0;
        check(err_main, "scoreboard entries left", 32'd0, 32'(exp_unc.num()));
        report_test(start);

        total = err_main + err_chk;
        $display("Tests %0d, requests %0d, bursts checked %0d, errors %0d",
                 tests_run, sent, checked, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
source/wb_pkg.sv
source/wb_dispatch.sv
source/wb_line_buffer.sv
source/wb_write_arbiter.sv
source/wb_top.sv
test/wb_axi_slave.sv
test/wb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the write-back path testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f sim.f --top-module wb_tb

out=$(./obj_dir/Vwb_tb)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
